//--- dv/alu_sva.sv
`timescale 1ns/1ps

module alu_sva (
    input logic                     div_ready,
    input logic                     rst_n,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_we,
    input logic [alu_pkg::adr_w-1:0] wb_adr,
    input logic                     wb_ack
);
    import alu_pkg::*;

    logic       op_req;
    logic [5:0] op_wait;

    assign op_req = wb_cyc && wb_stb && wb_we && (wb_adr == reg_op);

    // cycles an op write has been waiting
    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n)
            op_wait <= '0;
        else if (!op_req || wb_ack)
            op_wait <= '0;
        else if (op_wait != 6'h3f)
            op_wait <= op_wait + 1'b1;
    end

    ack_needs_request: assert property (@(posedge div_ready) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without an active request");

    ack_single_cycle: assert property (@(posedge div_ready) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    ack_low_after_reset: assert property (@(posedge div_ready)
        $rose(rst_n) |-> !wb_ack)
        else $error("wb_ack high in the first cycle after reset");

    op_write_acked: assert property (@(posedge div_ready) disable iff (!rst_n)
        op_wait <= 6'd40)
        else $error("operation write not acknowledged within 40 cycles");

endmodule

bind alu_wb_top alu_sva i_alu_sva (
    .div_ready (div_ready),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack)
);

//--- dv/tb_alu.sv
`timescale 1ns/1ps

module tb_alu;
    import alu_pkg::*;

    localparam int n_ops     = 128;  // alu operations issued over all tests
    localparam int ack_limit = 60;   // cycles a single transfer may take
    localparam int clk_half  = 10;

    localparam logic [data_w-1:0] corner_a [0:3] = '{32'h7fffffff, 32'h80000000,
                                                    32'h00000000, 32'hffffffff};
    localparam logic [data_w-1:0] corner_b [0:3] = '{32'h00000001, 32'hffffffff,
                                                    32'h80000000, 32'h00000001};
    localparam logic [data_w-1:0] dvd_list [0:5] = '{32'h00000007, 32'hfffffff9,
                                                    32'h00000007, 32'hfffffff9,
                                                    32'h12345678, 32'h80000000};
    localparam logic [data_w-1:0] dvs_list [0:5] = '{32'h00000002, 32'h00000002,
                                                    32'hfffffffe, 32'hfffffffe,
                                                    32'h00000000, 32'hffffffff};

    logic              div_ready;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [adr_w-1:0]  wb_adr;
    logic [data_w-1:0] wb_dat_w;
    logic [3:0]        wb_sel;
    logic [data_w-1:0] cp0_data;
    logic [data_w-1:0] wb_dat_r;
    logic              wb_ack;

    // architectural state predicted by the model
    logic [data_w-1:0] m_y;
    logic [data_w-1:0] m_hi;
    logic [data_w-1:0] m_lo;
    logic              m_ovf;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;

    alu_wb_top i_alu_wb_top (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .cp0_data  (cp0_data),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    initial begin
        div_ready = 1'b0;
        forever #(clk_half) div_ready = ~div_ready;
    end

    // galois form stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h80200003;
        return out;
    endfunction

    function automatic logic [data_w-1:0] rand_word();
        logic [data_w-1:0] w;
        w = '0;
        for (int i = 0; i < data_w; i++)
            w = {w[data_w-2:0], lfsr_bit()};
        return w;
    endfunction

    function automatic void ref_model(input logic [op_w-1:0] op, input logic [data_w-1:0] a,
                                      input logic [data_w-1:0] b);
        logic [data_w:0]     wide;
        logic [2*data_w-1:0] full;
        logic [2*data_w-1:0] quo;
        logic [2*data_w-1:0] rem;
        longint              sa;
        longint              sb;
        logic [4:0]          sh;
        sh    = a[4:0];
        sa    = longint'($signed(a));
        sb    = longint'($signed(b));
        m_ovf = 1'b0;
        case (op)
            op_add: begin
                wide  = {a[data_w-1], a} + {b[data_w-1], b};
                m_y   = wide[data_w-1:0];
                m_ovf = wide[data_w] != wide[data_w-1]; // sign-extended carry disagrees
            end
            op_sub: begin
                wide  = {a[data_w-1], a} - {b[data_w-1], b};
                m_y   = wide[data_w-1:0];
                m_ovf = wide[data_w] != wide[data_w-1];
            end
            op_addu: m_y = a + b;
            op_subu: m_y = a - b;
            op_slt:  m_y = (sa < sb) ? 32'd1 : 32'd0;
            op_sltu: m_y = (a < b) ? 32'd1 : 32'd0;
            op_and:  m_y = a & b;
            op_or:   m_y = a | b;
            op_nor:  m_y = ~(a | b);
            op_xor:  m_y = a ^ b;
            op_lui:  m_y = b << 16;
            op_sll:  m_y = b << sh;
            op_srl:  m_y = b >> sh;
            op_sra:  m_y = 32'(sb >>> sh);
            op_mult: begin
                full = sa * sb;
                {m_hi, m_lo} = full;
            end
            op_multu: {m_hi, m_lo} = {32'b0, a} * {32'b0, b};
            op_div, op_divu: begin
                if (b == '0) begin
                    m_hi = a;
                    m_lo = '1;
                end else if (op == op_div) begin
                    quo  = sa / sb;  // truncates toward zero
                    rem  = sa % sb;
                    m_lo = quo[data_w-1:0];
                    m_hi = rem[data_w-1:0];
                end else begin
                    m_lo = a / b;
                    m_hi = a % b;
                end
            end
            op_mthi: m_hi = a;
            op_mtlo: m_lo = a;
            op_mfhi: m_y = m_hi;
            op_mflo: m_y = m_lo;
            op_mfc0: m_y = cp0_data;
            default: m_y = m_y;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("** Error: %s expected %h, got %h", name, expected, got);
            errors++;
        end
    endtask

    task automatic wait_ack(output logic [data_w-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge div_ready);
        while (!wb_ack && waited < ack_limit) begin
            @(posedge div_ready);
            waited++;
        end
        rdata = wb_dat_r;
        checks++;
        assert (wb_ack) else begin
            $display("no acknowledge from the DUT within %0d cycles at address %0d",
                     ack_limit, wb_adr);
            errors++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [adr_w-1:0] adr, input logic [data_w-1:0] data);
        logic [data_w-1:0] unused;
        @(posedge div_ready);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(unused);
    endtask

    task automatic bus_read(input logic [adr_w-1:0] adr, output logic [data_w-1:0] data);
        @(posedge div_ready);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(data);
    endtask

    task automatic check_state();
        logic [data_w-1:0] v;
        bus_read(reg_y, v);
        check_value("y", v, m_y);
        bus_read(reg_hi, v);
        check_value("hi", v, m_hi);
        bus_read(reg_lo, v);
        check_value("lo", v, m_lo);
        bus_read(reg_status, v);
        check_value("status", v, {31'b0, m_ovf});
    endtask

    task automatic run_op(input logic [op_w-1:0] op, input logic [data_w-1:0] a,
                          input logic [data_w-1:0] b);
        bus_write(reg_a, a);
        bus_write(reg_b, b);
        bus_write(reg_op, {24'b0, op}); // returns once the result is in
        ref_model(op, a, b);
        check_state();
    endtask

    task automatic report_test(input string name, input int checks_before,
                               input int errors_before);
        $display("%-22s %0d checks, %0d errors", name, checks - checks_before,
                 errors - errors_before);
    endtask

    task automatic reset_values_and_operands();
        int                c0;
        int                e0;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] v;
        c0 = checks;
        e0 = errors;
        check_state();
        for (int i = 0; i < 4; i++) begin
            a = rand_word();
            b = rand_word();
            bus_write(reg_a, a);
            bus_write(reg_b, b);
            bus_read(reg_a, v);
            check_value("a", v, a);
            bus_read(reg_b, v);
            check_value("b", v, b);
        end
        report_test("reset and operands", c0, e0);
    endtask

    task automatic add_and_subtract();
        int               c0;
        int               e0;
        logic [op_w-1:0]  ops [0:3];
        c0 = checks;
        e0 = errors;
        ops = '{op_add, op_addu, op_sub, op_subu};
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++)
                run_op(ops[k], corner_a[i], corner_b[i]);
            for (int i = 0; i < 3; i++)
                run_op(ops[k], rand_word(), rand_word());
        end
        // overflow then a logic op clears it
        run_op(op_add, 32'h7fffffff, 32'h00000001);
        run_op(op_and, 32'hf0f0f0f0, 32'h0ff00ff0);
        report_test("add and subtract", c0, e0);
    endtask

    task automatic logic_and_shifts();
        int              c0;
        int              e0;
        logic [op_w-1:0] ops [0:9];
        c0 = checks;
        e0 = errors;
        ops = '{op_slt, op_sltu, op_and, op_or, op_nor, op_xor, op_lui, op_sll, op_srl, op_sra};
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < 4; i++)
                run_op(ops[k], corner_a[i], corner_b[i]); // shift amounts 31, 0, 0, 31
            for (int i = 0; i < 2; i++)
                run_op(ops[k], rand_word(), rand_word());
        end
        report_test("logic and shifts", c0, e0);
    endtask

    task automatic multiply();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            run_op(op_mult, corner_a[i], corner_b[i]);
            run_op(op_multu, corner_a[i], corner_b[i]);
        end
        for (int i = 0; i < 3; i++) begin
            run_op(op_mult, rand_word(), rand_word());
            run_op(op_multu, rand_word(), rand_word());
        end
        report_test("multiply", c0, e0);
    endtask

    task automatic divide();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            run_op(op_div, dvd_list[i], dvs_list[i]);
            run_op(op_divu, dvd_list[i], dvs_list[i]);
        end
        for (int i = 0; i < 2; i++) begin
            run_op(op_div, rand_word(), rand_word());
            run_op(op_divu, rand_word(), rand_word());
        end
        run_op(op_div, rand_word(), rand_word() & 32'h0000ffff); // small divisor
        run_op(op_divu, rand_word(), rand_word() & 32'h0000ffff);
        report_test("divide", c0, e0);
    endtask

    task automatic hilo_moves();
        int                c0;
        int                e0;
        logic [data_w-1:0] cp0;
        c0 = checks;
        e0 = errors;
        run_op(op_mthi, rand_word(), 32'h0);
        run_op(op_mtlo, rand_word(), 32'h0);
        run_op(op_mfhi, 32'h0, 32'h0);
        run_op(op_mflo, 32'h0, 32'h0);
        cp0 = rand_word();
        @(posedge div_ready);
        cp0_data <= cp0;
        run_op(op_mfc0, 32'h0, 32'h0);
        @(posedge div_ready);
        cp0_data <= ~cp0;
        run_op(op_mfc0, 32'h0, 32'h0);
        report_test("hi/lo moves and cp0", c0, e0);
    endtask

    initial begin
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = 4'hf;
        cp0_data   = '0;
        rst_n      = 1'b0;
        m_y        = '0;
        m_hi       = '0;
        m_lo       = '0;
        m_ovf      = 1'b0;
        lfsr_state = 32'd85;
        checks     = 0;
        errors     = 0;
        repeat (4) @(posedge div_ready);
        rst_n <= 1'b1;
        reset_values_and_operands();
        add_and_subtract();
        logic_and_shifts();
        multiply();
        divide();
        hilo_moves();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #(n_ops * 60 * 2 * clk_half);
        $display("watchdog expired, the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- rtl/alu_master.sv
`timescale 1ns/1ps

module alu_master (
    input  logic                        div_ready,
    input  logic                        rst_n,
    input  logic [alu_pkg::data_w-1:0]   op_a,
    input  logic [alu_pkg::data_w-1:0]   op_b,
    input  logic [alu_pkg::op_w-1:0]     op_code,
    input  logic                        issue,
    input  logic [alu_pkg::data_w-1:0]   cp0_data,
    input  logic [alu_pkg::data_w-1:0]   hi,
    input  logic [alu_pkg::data_w-1:0]   lo,
    output logic                        done,
    output logic [alu_pkg::data_w-1:0]   y_next,
    output logic [2*alu_pkg::data_w-1:0] hilo_next,
    output logic                        y_we,
    output logic                        hilo_we,
    output logic                        ovf
);
    import alu_pkg::*;

    logic [data_w-1:0]   sum;
    logic [data_w-1:0]   diff;
    logic                is_mul;
    logic                is_div;
    logic                md_sign;
    logic                mul_start;
    logic                div_start;
    logic                mul_rdy;
    logic                div_rdy;
    logic [2*data_w-1:0] mul_result;
    logic [2*data_w-1:0] div_result;
    logic [2*data_w-1:0] md_result;
    logic                md_busy;
    logic                md_done;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    assign is_mul  = (op_code == op_mult) || (op_code == op_multu);
    assign is_div  = (op_code == op_div) || (op_code == op_divu);
    assign md_sign = (op_code == op_mult) || (op_code == op_div);

    assign mul_start = issue && is_mul && !md_busy;
    assign div_start = issue && is_div && !md_busy;

    // single-cycle ops finish with issue
    assign done = (issue && !is_mul && !is_div) || md_done;

    always_comb begin
        y_next    = '0;
        hilo_next = md_result;
        y_we      = 1'b1;
        hilo_we   = 1'b0;
        ovf       = 1'b0;
        case (op_code)
            op_add: begin
                y_next = sum;
                ovf    = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
            end
            op_addu: y_next = sum;
            op_sub: begin
                y_next = diff;
                ovf    = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
            end
            op_subu: y_next = diff;
            op_slt:  y_next = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            op_sltu: y_next = {{(data_w-1){1'b0}}, op_a < op_b};
            op_and:  y_next = op_a & op_b;
            op_or:   y_next = op_a | op_b;
            op_nor:  y_next = ~(op_a | op_b);
            op_xor:  y_next = op_a ^ op_b;
            op_lui:  y_next = {op_b[15:0], 16'b0};
            op_sll:  y_next = op_b << op_a[4:0];
            op_srl:  y_next = op_b >> op_a[4:0];
            op_sra:  y_next = $signed(op_b) >>> op_a[4:0];
            op_mfhi: y_next = hi;
            op_mflo: y_next = lo;
            op_mfc0: y_next = cp0_data;
            op_mthi: begin
                y_we      = 1'b0;
                hilo_we   = 1'b1;
                hilo_next = {op_a, lo};
            end
            op_mtlo: begin
                y_we      = 1'b0;
                hilo_we   = 1'b1;
                hilo_next = {hi, op_a};
            end
            op_mult, op_multu, op_div, op_divu: begin
                y_we    = 1'b0;
                hilo_we = 1'b1;
            end
            default: y_we = 1'b0; // unknown code completes with no write
        endcase
    end

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            md_busy   <= 1'b0;
            md_done   <= 1'b0;
            md_result <= '0;
        end else begin
            md_done <= md_busy && (mul_rdy || div_rdy);
            if (mul_start || div_start) begin
                md_busy <= 1'b1;
            end else if (md_busy && (mul_rdy || div_rdy)) begin
                md_busy   <= 1'b0;
                md_result <= mul_rdy ? mul_result : div_result;
            end
        end
    end

    mul_unit i_mul_unit (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .start     (mul_start),
        .sign      (md_sign),
        .a         (op_a),
        .b         (op_b),
        .result    (mul_result),
        .ready     (mul_rdy)
    );

    div_unit i_div_unit (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .start     (div_start),
        .sign      (md_sign),
        .a         (op_a),
        .b         (op_b),
        .result    (div_result),
        .ready     (div_rdy)
    );

endmodule

//--- rtl/alu_pkg.sv
package alu_pkg;

    localparam int data_w = 32;
    localparam int adr_w  = 3;
    localparam int op_w   = 8;

    // iteration count shared by multiply and divide
    localparam int div_cycles = 32;

    // word addresses
    localparam logic [adr_w-1:0] reg_a      = 3'd0;
    localparam logic [adr_w-1:0] reg_b      = 3'd1;
    localparam logic [adr_w-1:0] reg_op     = 3'd2;
    localparam logic [adr_w-1:0] reg_y      = 3'd3;
    localparam logic [adr_w-1:0] reg_hi     = 3'd4;
    localparam logic [adr_w-1:0] reg_lo     = 3'd5;
    localparam logic [adr_w-1:0] reg_status = 3'd6; // bit 0 overflow

    localparam logic [op_w-1:0] op_add   = 8'h20;
    localparam logic [op_w-1:0] op_addu  = 8'h21;
    localparam logic [op_w-1:0] op_sub   = 8'h22;
    localparam logic [op_w-1:0] op_subu  = 8'h23;
    localparam logic [op_w-1:0] op_and   = 8'h24;
    localparam logic [op_w-1:0] op_or    = 8'h25;
    localparam logic [op_w-1:0] op_xor   = 8'h26;
    localparam logic [op_w-1:0] op_nor   = 8'h27;
    localparam logic [op_w-1:0] op_slt   = 8'h2a;
    localparam logic [op_w-1:0] op_sltu  = 8'h2b;
    localparam logic [op_w-1:0] op_lui   = 8'h0f;
    localparam logic [op_w-1:0] op_sll   = 8'h40;
    localparam logic [op_w-1:0] op_srl   = 8'h42;
    localparam logic [op_w-1:0] op_sra   = 8'h43;
    localparam logic [op_w-1:0] op_mult  = 8'h18;
    localparam logic [op_w-1:0] op_multu = 8'h19;
    localparam logic [op_w-1:0] op_div   = 8'h1a;
    localparam logic [op_w-1:0] op_divu  = 8'h1b;
    localparam logic [op_w-1:0] op_mfhi  = 8'h10;
    localparam logic [op_w-1:0] op_mthi  = 8'h11;
    localparam logic [op_w-1:0] op_mflo  = 8'h12;
    localparam logic [op_w-1:0] op_mtlo  = 8'h13;
    localparam logic [op_w-1:0] op_mfc0  = 8'h50;

endpackage

//--- rtl/alu_wb_top.sv
`timescale 1ns/1ps

module alu_wb_top (
    input  logic                      div_ready,
    input  logic                      rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [alu_pkg::adr_w-1:0]  wb_adr,
    input  logic [alu_pkg::data_w-1:0] wb_dat_w,
    input  logic [3:0]                wb_sel,
    input  logic [alu_pkg::data_w-1:0] cp0_data,
    output logic [alu_pkg::data_w-1:0] wb_dat_r,
    output logic                      wb_ack
);
    import alu_pkg::*;

    logic [data_w-1:0]   op_a;
    logic [data_w-1:0]   op_b;
    logic [op_w-1:0]     op_code;
    logic                issue;
    logic                done;
    logic [data_w-1:0]   y_next;
    logic [2*data_w-1:0] hilo_next;
    logic                y_we;
    logic                hilo_we;
    logic                ovf;
    logic [data_w-1:0]   y;
    logic [data_w-1:0]   hi;
    logic [data_w-1:0]   lo;
    logic                ovf_flag;

    wb_issue_stage i_wb_issue_stage (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .done      (done),
        .y         (y),
        .hi        (hi),
        .lo        (lo),
        .ovf_flag  (ovf_flag),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_code   (op_code),
        .issue     (issue)
    );

    alu_master i_alu_master (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_code   (op_code),
        .issue     (issue),
        .cp0_data  (cp0_data),
        .hi        (hi),
        .lo        (lo),
        .done      (done),
        .y_next    (y_next),
        .hilo_next (hilo_next),
        .y_we      (y_we),
        .hilo_we   (hilo_we),
        .ovf       (ovf)
    );

    result_stage i_result_stage (
        .div_ready (div_ready),
        .rst_n     (rst_n),
        .done      (done),
        .y_we      (y_we),
        .hilo_we   (hilo_we),
        .y_next    (y_next),
        .hilo_next (hilo_next),
        .ovf       (ovf),
        .y         (y),
        .hi        (hi),
        .lo        (lo),
        .ovf_flag  (ovf_flag)
    );

endmodule

//--- rtl/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                        div_ready,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        sign,
    input  logic [alu_pkg::data_w-1:0]   a,
    input  logic [alu_pkg::data_w-1:0]   b,
    output logic [2*alu_pkg::data_w-1:0] result,
    output logic                        ready
);
    import alu_pkg::*;

    logic [data_w-1:0]             a_mag;
    logic [data_w-1:0]             b_mag;
    logic [data_w-1:0]             rem;
    logic [data_w-1:0]             quo;
    logic [data_w-1:0]             dvs;
    logic [data_w-1:0]             dvd;
    logic [data_w:0]               shifted;
    logic [data_w:0]               trial;
    logic [data_w-1:0]             rem_n;
    logic [data_w-1:0]             quo_n;
    logic [$clog2(div_cycles)-1:0] cnt;
    logic                          neg_q;
    logic                          neg_r;
    logic                          dvz;
    logic                          busy;

    assign a_mag = (sign && a[data_w-1]) ? -a : a;
    assign b_mag = (sign && b[data_w-1]) ? -b : b;

    // restoring step keeps the difference only when it stays non-negative
    assign shifted = {rem, quo[data_w-1]};
    assign trial   = shifted - {1'b0, dvs};
    assign rem_n   = trial[data_w] ? shifted[data_w-1:0] : trial[data_w-1:0];
    assign quo_n   = {quo[data_w-2:0], ~trial[data_w]};

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            rem    <= '0;
            quo    <= '0;
            dvs    <= '0;
            dvd    <= '0;
            cnt    <= '0;
            neg_q  <= 1'b0;
            neg_r  <= 1'b0;
            dvz    <= 1'b0;
            busy   <= 1'b0;
            ready  <= 1'b0;
            result <= '0;
        end else begin
            ready <= 1'b0;
            if (start) begin
                rem   <= '0;
                quo   <= a_mag;
                dvs   <= b_mag;
                dvd   <= a;
                cnt   <= '0;
                neg_q <= sign && (a[data_w-1] ^ b[data_w-1]);
                neg_r <= sign && a[data_w-1]; // remainder follows dividend
                dvz   <= (b == '0);
                busy  <= 1'b1;
            end else if (busy) begin
                rem <= rem_n;
                quo <= quo_n;
                cnt <= cnt + 1'b1;
                if (cnt == div_cycles - 1) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                    if (dvz)
                        result <= {dvd, {data_w{1'b1}}};
                    else
                        result <= {neg_r ? -rem_n : rem_n, neg_q ? -quo_n : quo_n};
                end
            end
        end
    end

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                        div_ready,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        sign,
    input  logic [alu_pkg::data_w-1:0]   a,
    input  logic [alu_pkg::data_w-1:0]   b,
    output logic [2*alu_pkg::data_w-1:0] result,
    output logic                        ready
);
    import alu_pkg::*;

    logic [data_w-1:0]             a_mag;
    logic [data_w-1:0]             b_mag;
    logic [2*data_w-1:0]           mcand;
    logic [2*data_w-1:0]           prod;
    logic [2*data_w-1:0]           prod_next;
    logic [data_w-1:0]             mplier;
    logic [$clog2(div_cycles)-1:0] cnt;
    logic                          neg;
    logic                          busy;

    assign a_mag     = (sign && a[data_w-1]) ? -a : a;
    assign b_mag     = (sign && b[data_w-1]) ? -b : b;
    assign prod_next = prod + (mplier[0] ? mcand : '0);

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            mcand  <= '0;
            mplier <= '0;
            prod   <= '0;
            cnt    <= '0;
            neg    <= 1'b0;
            busy   <= 1'b0;
            ready  <= 1'b0;
            result <= '0;
        end else begin
            ready <= 1'b0;
            if (start) begin
                mcand  <= {{data_w{1'b0}}, a_mag};
                mplier <= b_mag;
                prod   <= '0;
                cnt    <= '0;
                neg    <= sign && (a[data_w-1] ^ b[data_w-1]);
                busy   <= 1'b1;
            end else if (busy) begin
                prod   <= prod_next;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
                cnt    <= cnt + 1'b1;
                if (cnt == div_cycles - 1) begin
                    busy   <= 1'b0;
                    ready  <= 1'b1;
                    result <= neg ? -prod_next : prod_next; // sign fix
                end
            end
        end
    end

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                        div_ready,
    input  logic                        rst_n,
    input  logic                        done,
    input  logic                        y_we,
    input  logic                        hilo_we,
    input  logic [alu_pkg::data_w-1:0]   y_next,
    input  logic [2*alu_pkg::data_w-1:0] hilo_next,
    input  logic                        ovf,
    output logic [alu_pkg::data_w-1:0]   y,
    output logic [alu_pkg::data_w-1:0]   hi,
    output logic [alu_pkg::data_w-1:0]   lo,
    output logic                        ovf_flag
);
    import alu_pkg::*;

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            y        <= '0;
            hi       <= '0;
            lo       <= '0;
            ovf_flag <= 1'b0;
        end else if (done) begin
            ovf_flag <= ovf; // every op rewrites the flag
            if (y_we)
                y <= y_next;
            if (hilo_we) begin
                hi <= hilo_next[2*data_w-1:data_w];
                lo <= hilo_next[data_w-1:0];
            end
        end
    end

endmodule

//--- rtl/wb_issue_stage.sv
`timescale 1ns/1ps

module wb_issue_stage (
    input  logic                      div_ready,
    input  logic                      rst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [alu_pkg::adr_w-1:0]  wb_adr,
    input  logic [alu_pkg::data_w-1:0] wb_dat_w,
    input  logic [3:0]                wb_sel,   // full-word writes only
    input  logic                      done,
    input  logic [alu_pkg::data_w-1:0] y,
    input  logic [alu_pkg::data_w-1:0] hi,
    input  logic [alu_pkg::data_w-1:0] lo,
    input  logic                      ovf_flag,
    output logic [alu_pkg::data_w-1:0] wb_dat_r,
    output logic                      wb_ack,
    output logic [alu_pkg::data_w-1:0] op_a,
    output logic [alu_pkg::data_w-1:0] op_b,
    output logic [alu_pkg::op_w-1:0]   op_code,
    output logic                      issue
);
    import alu_pkg::*;

    logic busy;
    logic req;

    // held request is ignored while acked or an op is in flight
    assign req = wb_cyc && wb_stb && !wb_ack && !busy;

    always_ff @(posedge div_ready or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            issue   <= 1'b0;
            busy    <= 1'b0;
            op_a    <= '0;
            op_b    <= '0;
            op_code <= '0;
        end else begin
            wb_ack <= 1'b0;
            issue  <= 1'b0;
            if (done) begin
                busy   <= 1'b0;
                wb_ack <= 1'b1;
            end else if (req) begin
                if (wb_we && wb_adr == reg_op) begin
                    issue   <= 1'b1;
                    busy    <= 1'b1;
                    op_code <= wb_dat_w[op_w-1:0];
                end else begin
                    wb_ack <= 1'b1;
                    if (wb_we && wb_adr == reg_a)
                        op_a <= wb_dat_w;
                    if (wb_we && wb_adr == reg_b)
                        op_b <= wb_dat_w;
                end
            end
        end
    end

    always_comb begin
        case (wb_adr)
            reg_a:      wb_dat_r = op_a;
            reg_b:      wb_dat_r = op_b;
            reg_op:     wb_dat_r = {{(data_w-op_w){1'b0}}, op_code};
            reg_y:      wb_dat_r = y;
            reg_hi:     wb_dat_r = hi;
            reg_lo:     wb_dat_r = lo;
            reg_status: wb_dat_r = {{(data_w-1){1'b0}}, ovf_flag};
            default:    wb_dat_r = '0;
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log && verilator --binary --timing --assert -Wno-fatal --top-module tb_alu \
    -f verilog.f && ./obj_dir/Vtb_alu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

//--- verilog.f
rtl/alu_pkg.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/alu_master.sv
rtl/wb_issue_stage.sv
rtl/result_stage.sv
rtl/alu_wb_top.sv
dv/alu_sva.sv
dv/tb_alu.sv
